//--- list.f
hw/riscv_pkg.sv
hw/riscv_instructions_cache.sv
hw/riscv_data_cache.sv
hw/riscv_timer_irq.sv
hw/riscv_io_decode.sv
hw/riscv_core_memsys.sv
tb/tb_mem_model.sv
tb/tb_riscv_core_memsys.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_riscv_core_memsys -f list.f

out=$(./obj_dir/Vtb_riscv_core_memsys)
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

//--- tb/tb_riscv_core_memsys.sv
module tb_riscv_core_memsys;
  timeunit 1ns;
  timeprecision 1ps;

  import riscv_pkg::*;

  localparam int TIMEOUT = 200;

  logic       i_riscv_core_clk;
  logic       i_rst_n;
  xlen_t      i_pc;
  inst_t      o_cpu_instr_out;
  logic       o_icache_stall;
  logic       i_cpu_wren;
  logic       i_cpu_rden;
  store_src_t i_cpu_store_src;
  xlen_t      i_cpu_addr;
  xlen_t      i_cpu_store_data;
  xlen_t      o_cpu_load_data;
  logic       o_cpu_stall;
  logic       i_imem_ready;
  block_t     i_imem_data_out;
  blk_addr_t  o_imem_addr;
  logic       o_imem_fsm_rden;
  logic       i_dmem_ready;
  block_t     i_dmem_data_out;
  blk_addr_t  o_dmem_addr;
  logic       o_dmem_fsm_rden;
  logic       o_dmem_fsm_wren;
  block_t     o_dmem_cache_data_out;
  logic       i_fifo_full;
  logic [7:0] o_uart_tx_data;
  logic       o_uart_tx_valid;
  logic       o_timer_irq;

  logic [7:0] shadow [MEM_SIZE];                   // Expected dmem contents as the CPU sees them.
  int         test_errors  = 0;
  int         tests_passed = 0;
  int         tests_failed = 0;
  int         uart_count   = 0;
  logic [7:0] uart_last    = '0;
  int         wb_count     = 0;
  block_t     wb_data      = '0;

  riscv_core_memsys u_dut (.*);

  tb_mem_model u_imem (
    .i_clk  (i_riscv_core_clk),
    .i_rst_n(i_rst_n),
    .i_rden (o_imem_fsm_rden),
    .i_wren (1'b0),
    .i_addr (o_imem_addr),
    .i_wdata('0),
    .o_ready(i_imem_ready),
    .o_rdata(i_imem_data_out)
  );

  tb_mem_model u_dmem (
    .i_clk  (i_riscv_core_clk),
    .i_rst_n(i_rst_n),
    .i_rden (o_dmem_fsm_rden),
    .i_wren (o_dmem_fsm_wren),
    .i_addr (o_dmem_addr),
    .i_wdata(o_dmem_cache_data_out),
    .o_ready(i_dmem_ready),
    .o_rdata(i_dmem_data_out)
  );

  always #20 i_riscv_core_clk = ~i_riscv_core_clk;

  always @(negedge i_riscv_core_clk) begin
    if (o_uart_tx_valid) begin
      uart_count++;
      uart_last = o_uart_tx_data;
    end
    if (o_dmem_fsm_wren && i_dmem_ready) begin
      wb_count++;
      wb_data = o_dmem_cache_data_out;
    end
  end

  function automatic logic [7:0] mem_pattern(int unsigned a);
    int unsigned h;
    h = (a * 32'h93) ^ (a >> 8) ^ 32'h5a;
    return h[7:0];
  endfunction

  function automatic inst_t ref_inst(xlen_t pc);
    xlen_t off;
    int    a;
    off = pc - KERNEL_PC;
    a   = int'(off[15:0]) & ~3;
    return {mem_pattern(a + 3), mem_pattern(a + 2), mem_pattern(a + 1), mem_pattern(a)};
  endfunction

  function automatic void ref_store(xlen_t addr, store_src_t sz, xlen_t data);
    for (int b = 0; b < (1 << sz); b++) begin
      shadow[int'(addr[15:0]) + b] = data[8*b +: 8];
    end
  endfunction

  function automatic xlen_t ref_load(xlen_t addr);
    xlen_t r;
    int    a;
    a = int'(addr[15:0]) & ~7;
    for (int b = 0; b < 8; b++) begin
      r[8*b +: 8] = shadow[a + b];
    end
    return r;
  endfunction

  function automatic block_t ref_block(blk_addr_t blk);
    block_t r;
    for (int b = 0; b < DATAPBLOCK; b++) begin
      r[8*b +: 8] = shadow[int'(blk) * DATAPBLOCK + b];
    end
    return r;
  endfunction

  task automatic report_error(string msg);
    $display("ERROR %s", msg);
    test_errors++;
  endtask

  task automatic check_inst(string name, inst_t got, inst_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_load(string name, xlen_t got, xlen_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_block(string name, block_t got, block_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_irq(string name, bit got, bit exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_uart(string name, logic [7:0] got, logic [7:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic finish_test(string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("[%s] ok", name);
    end else begin
      tests_failed++;
      $display("[%s] %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic fetch(xlen_t pc, output inst_t inst);
    int cyc;
    bit done;
    cyc  = 0;
    done = 1'b0;
    inst = '0;
    i_pc = pc;
    while (!done && cyc < TIMEOUT) begin
      @(negedge i_riscv_core_clk);
      if (!o_icache_stall) begin
        done = 1'b1;
        inst = o_cpu_instr_out;
      end
      cyc++;
    end
    if (!done) begin
      report_error($sformatf("fetch at %h still stalled after %0d cycles", pc, TIMEOUT));
    end
    @(posedge i_riscv_core_clk);
    #2;
  endtask

  // Requests stay up while stall is high; the access ends in the first cycle with stall low.
  task automatic finish_access(output xlen_t rdata);
    int cyc;
    bit done;
    cyc   = 0;
    done  = 1'b0;
    rdata = '0;
    while (!done && cyc < TIMEOUT) begin
      @(negedge i_riscv_core_clk);
      if (!o_cpu_stall) begin
        done  = 1'b1;
        rdata = o_cpu_load_data;
      end
      cyc++;
    end
    if (!done) begin
      report_error($sformatf("access at %h still stalled after %0d cycles",
                             i_cpu_addr, TIMEOUT));
    end
    @(posedge i_riscv_core_clk);
    #2;
    i_cpu_wren = 1'b0;
    i_cpu_rden = 1'b0;
  endtask

  task automatic access(logic wr, logic rd, store_src_t sz, xlen_t addr, xlen_t data,
                        output xlen_t rdata);
    i_cpu_wren       = wr;
    i_cpu_rden       = rd;
    i_cpu_store_src  = sz;
    i_cpu_addr       = addr;
    i_cpu_store_data = data;
    finish_access(rdata);
  endtask

  initial begin
    xlen_t      addr;
    xlen_t      data;
    xlen_t      rd;
    xlen_t      t;
    xlen_t      pcs [6];
    inst_t      inst;
    store_src_t sz;
    int         n;
    int         cyc;

    void'($urandom(32'h7c49906c));
    i_riscv_core_clk = 1'b0;
    i_rst_n          = 1'b0;
    i_pc             = KERNEL_PC;
    i_cpu_wren       = 1'b0;
    i_cpu_rden       = 1'b0;
    i_cpu_store_src  = ST_BYTE;
    i_cpu_addr       = '0;
    i_cpu_store_data = '0;
    i_fifo_full      = 1'b0;
    for (int a = 0; a < MEM_SIZE; a++) begin
      shadow[a] = mem_pattern(a);
    end
    repeat (4) @(posedge i_riscv_core_clk);
    #2;
    i_rst_n = 1'b1;

    for (int i = 0; i < 6; i++) begin
      pcs[i] = KERNEL_PC + (xlen_t'($urandom_range(0, 32'hFFFF)) & ~xlen_t'(3));
      repeat (2) begin
        fetch(pcs[i], inst);
        check_inst("o_cpu_instr_out", inst, ref_inst(pcs[i]));
      end
    end
    for (int i = 0; i < 6; i++) begin
      fetch(pcs[i], inst);
      check_inst("o_cpu_instr_out", inst, ref_inst(pcs[i]));
    end
    finish_test("fetch");

    for (int i = 0; i < 16; i++) begin
      sz   = store_src_t'(i % 4);
      addr = xlen_t'($urandom_range(0, 32'hEFFF)) & ~((xlen_t'(1) << sz) - 1);
      data = {$urandom, $urandom};
      access(1'b1, 1'b0, sz, addr, data, rd);
      ref_store(addr, sz, data);
      access(1'b0, 1'b1, ST_DWORD, addr, '0, rd);
      check_load("o_cpu_load_data", rd, ref_load(addr));
    end
    finish_test("store_load");

    addr = 64'h1230;
    data = {$urandom, $urandom};
    access(1'b1, 1'b0, ST_DWORD, addr, data, rd);
    ref_store(addr, ST_DWORD, data);
    n = wb_count;
    access(1'b0, 1'b1, ST_DWORD, addr + 64'h1000, '0, rd);   // Same index, other tag.
    check_load("o_cpu_load_data", rd, ref_load(addr + 64'h1000));
    if (wb_count != n + 1) begin
      report_error($sformatf("expected one dmem writeback on eviction, saw %0d", wb_count - n));
    end
    check_block("o_dmem_cache_data_out", wb_data, ref_block(blk_addr_t'(addr >> 4)));
    access(1'b0, 1'b1, ST_DWORD, addr, '0, rd);
    check_load("o_cpu_load_data", rd, ref_load(addr));
    finish_test("eviction");

    @(negedge i_riscv_core_clk);
    check_irq("o_timer_irq", o_timer_irq, 1'b0);
    @(posedge i_riscv_core_clk);
    #2;
    access(1'b0, 1'b1, ST_DWORD, TIMER_BASE, '0, t);
    access(1'b1, 1'b0, ST_DWORD, TIMER_BASE + 8, t + 20, rd);
    access(1'b0, 1'b1, ST_DWORD, TIMER_BASE + 8, '0, rd);
    check_load("o_cpu_load_data", rd, t + 20);
    @(negedge i_riscv_core_clk);
    check_irq("o_timer_irq", o_timer_irq, 1'b0);
    cyc = 0;
    while (!o_timer_irq && cyc < TIMEOUT) begin
      @(negedge i_riscv_core_clk);
      cyc++;
    end
    if (!o_timer_irq) begin
      report_error("timer interrupt did not rise after mtime passed mtimecmp");
    end
    @(posedge i_riscv_core_clk);
    #2;
    access(1'b1, 1'b0, ST_DWORD, TIMER_BASE + 8, '1, rd);
    @(negedge i_riscv_core_clk);
    check_irq("o_timer_irq", o_timer_irq, 1'b0);
    @(posedge i_riscv_core_clk);
    #2;
    finish_test("timer");

    n    = uart_count;
    data = xlen_t'($urandom);
    access(1'b1, 1'b0, ST_BYTE, UART_ADDR, data, rd);
    if (uart_count != n + 1) begin
      report_error($sformatf("expected one UART valid cycle, saw %0d", uart_count - n));
    end
    check_uart("o_uart_tx_data", uart_last, data[7:0]);
    i_fifo_full      = 1'b1;
    n                = uart_count;
    data             = xlen_t'($urandom);
    i_cpu_wren       = 1'b1;
    i_cpu_store_src  = ST_BYTE;
    i_cpu_addr       = UART_ADDR;
    i_cpu_store_data = data;
    repeat (6) begin
      @(negedge i_riscv_core_clk);
      if (!o_cpu_stall || o_uart_tx_valid) begin
        report_error("UART store went through while the FIFO was full");
      end
    end
    @(posedge i_riscv_core_clk);
    #2;
    i_fifo_full = 1'b0;
    finish_access(rd);
    if (uart_count != n + 1) begin
      report_error($sformatf("expected one UART valid cycle after release, saw %0d",
                             uart_count - n));
    end
    check_uart("o_uart_tx_data", uart_last, data[7:0]);
    finish_test("uart");

    $display("tests: %0d ok, %0d failing", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- tb/tb_mem_model.sv
module tb_mem_model (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_rden,
  input  logic                 i_wren,
  input  riscv_pkg::blk_addr_t i_addr,
  input  riscv_pkg::block_t    i_wdata,
  output logic                 o_ready,
  output riscv_pkg::block_t    o_rdata
);
  timeunit 1ns;
  timeprecision 1ps;

  import riscv_pkg::*;

  logic [7:0]  mem [MEM_SIZE];
  logic        busy     = 1'b0;
  logic        ready    = 1'b0;
  block_t      rdata    = '0;
  int unsigned wait_cnt = 0;

  function automatic logic [7:0] fill_byte(int unsigned a);
    int unsigned h;
    h = (a * 32'h93) ^ (a >> 8) ^ 32'h5a;          // Every address bit reaches the low byte.
    return h[7:0];
  endfunction

  initial begin
    for (int a = 0; a < MEM_SIZE; a++) begin
      mem[a] = fill_byte(a);
    end
  end

  assign o_ready = ready;
  assign o_rdata = rdata;

  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      busy  <= 1'b0;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (ready) begin
        busy <= 1'b0;                              // The cache drops or changes its request now.
      end else if (!busy && (i_rden || i_wren)) begin
        busy     <= 1'b1;
        wait_cnt <= $urandom_range(6, 1) - 1;
      end else if (busy && wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1;
      end else if (busy) begin
        ready <= 1'b1;
        for (int b = 0; b < DATAPBLOCK; b++) begin
          rdata[8*b +: 8] <= mem[int'(i_addr) * DATAPBLOCK + b];
          if (i_wren) begin
            mem[int'(i_addr) * DATAPBLOCK + b] <= i_wdata[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

//--- hw/riscv_core_memsys.sv
module riscv_core_memsys (
  input  logic                        i_riscv_core_clk,
  input  logic                        i_rst_n,
  input  riscv_pkg::xlen_t            i_pc,
  output riscv_pkg::inst_t            o_cpu_instr_out,
  output logic                        o_icache_stall,
  input  logic                        i_cpu_wren,
  input  logic                        i_cpu_rden,
  input  riscv_pkg::store_src_t       i_cpu_store_src,
  input  riscv_pkg::xlen_t            i_cpu_addr,
  input  riscv_pkg::xlen_t            i_cpu_store_data,
  output riscv_pkg::xlen_t            o_cpu_load_data,
  output logic                        o_cpu_stall,
  input  logic                        i_imem_ready,
  input  riscv_pkg::block_t           i_imem_data_out,
  output riscv_pkg::blk_addr_t        o_imem_addr,
  output logic                        o_imem_fsm_rden,
  input  logic                        i_dmem_ready,
  input  riscv_pkg::block_t           i_dmem_data_out,
  output riscv_pkg::blk_addr_t        o_dmem_addr,
  output logic                        o_dmem_fsm_rden,
  output logic                        o_dmem_fsm_wren,
  output riscv_pkg::block_t           o_dmem_cache_data_out,
  input  logic                        i_fifo_full,
  output logic [7:0]                  o_uart_tx_data,
  output logic                        o_uart_tx_valid,
  output logic                        o_timer_irq
);

  import riscv_pkg::*;

  logic       dc_wren;
  logic       dc_rden;
  store_src_t dc_store_src;
  xlen_t      dc_data;
  logic       dc_stall;
  logic       timer_wren;
  timer_sel_t timer_regsel;
  xlen_t      timer_rdata;

  riscv_instructions_cache u_inst_cache (
    .i_icache_clk   (i_riscv_core_clk),
    .i_rst_n        (i_rst_n         ),
    .i_pc           (i_pc            ),
    .i_mem_ready    (i_imem_ready    ),
    .i_mem_data_out (i_imem_data_out ),
    .o_mem_addr     (o_imem_addr     ),
    .o_fsm_mem_rden (o_imem_fsm_rden ),
    .o_cpu_instr_out(o_cpu_instr_out ),
    .o_cpu_stall    (o_icache_stall  )
  );

  riscv_data_cache u_data_cache (
    .i_dcache_clk    (i_riscv_core_clk        ),
    .i_rst_n         (i_rst_n                 ),
    .i_cpu_wren      (dc_wren                 ),
    .i_cpu_rden      (dc_rden                 ),
    .i_store_src     (dc_store_src            ),
    .i_phys_addr     (i_cpu_addr[ADDR-1:0]    ),
    .i_cpu_data_in   (i_cpu_store_data        ),
    .i_mem_ready     (i_dmem_ready            ),
    .i_mem_data_out  (i_dmem_data_out         ),
    .o_fsm_mem_wren  (o_dmem_fsm_wren         ),
    .o_fsm_mem_rden  (o_dmem_fsm_rden         ),
    .o_mem_addr      (o_dmem_addr             ),
    .o_cache_data_out(o_dmem_cache_data_out   ),
    .o_cpu_data_out  (dc_data                 ),
    .o_cpu_stall     (dc_stall                )
  );

  riscv_timer_irq u_riscv_timer_irq (
    .i_timer_clk   (i_riscv_core_clk),
    .i_rst_n       (i_rst_n         ),
    .i_timer_wren  (timer_wren      ),
    .i_timer_regsel(timer_regsel    ),
    .i_timer_wdata (i_cpu_store_data),
    .o_timer_rdata (timer_rdata     ),
    .o_timer_irq   (o_timer_irq     )
  );

  riscv_io_decode u_io_decode (
    .i_cpu_wren      (i_cpu_wren      ),
    .i_cpu_rden      (i_cpu_rden      ),
    .i_cpu_store_src (i_cpu_store_src ),
    .i_cpu_addr      (i_cpu_addr      ),
    .i_cpu_store_data(i_cpu_store_data),
    .o_cpu_load_data (o_cpu_load_data ),
    .o_cpu_stall     (o_cpu_stall     ),
    .o_dc_wren       (dc_wren         ),
    .o_dc_rden       (dc_rden         ),
    .o_dc_store_src  (dc_store_src    ),
    .i_dc_data       (dc_data         ),
    .i_dc_stall      (dc_stall        ),
    .o_timer_wren    (timer_wren      ),
    .o_timer_regsel  (timer_regsel    ),
    .i_timer_rdata   (timer_rdata     ),
    .i_fifo_full     (i_fifo_full     ),
    .o_uart_tx_data  (o_uart_tx_data  ),
    .o_uart_tx_valid (o_uart_tx_valid )
  );

endmodule

//--- hw/riscv_io_decode.sv
module riscv_io_decode (
  input  logic                  i_cpu_wren,
  input  logic                  i_cpu_rden,
  input  riscv_pkg::store_src_t i_cpu_store_src,
  input  riscv_pkg::xlen_t      i_cpu_addr,
  input  riscv_pkg::xlen_t      i_cpu_store_data,
  output riscv_pkg::xlen_t      o_cpu_load_data,
  output logic                  o_cpu_stall,
  output logic                  o_dc_wren,
  output logic                  o_dc_rden,
  output riscv_pkg::store_src_t o_dc_store_src,
  input  riscv_pkg::xlen_t      i_dc_data,
  input  logic                  i_dc_stall,
  output logic                  o_timer_wren,
  output riscv_pkg::timer_sel_t o_timer_regsel,
  input  riscv_pkg::xlen_t      i_timer_rdata,
  input  logic                  i_fifo_full,
  output logic [7:0]            o_uart_tx_data,
  output logic                  o_uart_tx_valid
);

  import riscv_pkg::*;

  logic is_dc;
  logic is_timer;
  logic is_uart;
  logic uart_store;
  logic uart_blocked;

  assign is_dc    = (i_cpu_addr < TIMER_BASE);     // Everything below the timer is cached.
  assign is_timer = (i_cpu_addr[MXLEN-1:4] == TIMER_BASE[MXLEN-1:4]);
  assign is_uart  = (i_cpu_addr == UART_ADDR);

  assign o_dc_wren      = i_cpu_wren && is_dc;
  assign o_dc_rden      = i_cpu_rden && is_dc;
  assign o_dc_store_src = i_cpu_store_src;

  assign o_timer_wren   = i_cpu_wren && is_timer;
  assign o_timer_regsel = i_cpu_addr[3];

  assign uart_store      = i_cpu_wren && is_uart;
  assign uart_blocked    = uart_store && i_fifo_full;
  assign o_uart_tx_valid = uart_store && !i_fifo_full;
  assign o_uart_tx_data  = i_cpu_store_data[7:0];

  always_comb begin
    if (is_dc) begin
      o_cpu_load_data = i_dc_data;
    end else if (is_timer) begin
      o_cpu_load_data = i_timer_rdata;
    end else begin
      o_cpu_load_data = '0;                        // UART and unmapped loads read zero.
    end
  end

  // The data cache only stalls on requests that were steered to it.
  assign o_cpu_stall = i_dc_stall || uart_blocked;

endmodule

//--- hw/riscv_timer_irq.sv
module riscv_timer_irq (
  input  logic                  i_timer_clk,
  input  logic                  i_rst_n,
  input  logic                  i_timer_wren,
  input  riscv_pkg::timer_sel_t i_timer_regsel,
  input  riscv_pkg::xlen_t      i_timer_wdata,
  output riscv_pkg::xlen_t      o_timer_rdata,
  output logic                  o_timer_irq
);

  import riscv_pkg::*;

  xlen_t mtime;
  xlen_t mtimecmp;
  logic  wr_mtime;
  logic  wr_mtimecmp;

  assign wr_mtime    = i_timer_wren && (i_timer_regsel == SEL_MTIME);
  assign wr_mtimecmp = i_timer_wren && (i_timer_regsel == SEL_MTIMECMP);

  always_ff @(posedge i_timer_clk) begin
    if (!i_rst_n) begin
      mtime <= '0;
    end else if (wr_mtime) begin
      mtime <= i_timer_wdata;                      // A write wins over the increment.
    end else begin
      mtime <= mtime + 1'b1;
    end
  end

  always_ff @(posedge i_timer_clk) begin
    if (!i_rst_n) begin
      mtimecmp <= '1;                              // Keeps the interrupt quiet after reset.
    end else if (wr_mtimecmp) begin
      mtimecmp <= i_timer_wdata;
    end
  end

  assign o_timer_rdata = (i_timer_regsel == SEL_MTIMECMP) ? mtimecmp : mtime;
  assign o_timer_irq   = (mtime >= mtimecmp);

endmodule

//--- hw/riscv_data_cache.sv
module riscv_data_cache (
  input  logic                        i_dcache_clk,
  input  logic                        i_rst_n,
  input  logic                        i_cpu_wren,
  input  logic                        i_cpu_rden,
  input  riscv_pkg::store_src_t       i_store_src,
  input  logic [riscv_pkg::ADDR-1:0]  i_phys_addr,
  input  riscv_pkg::xlen_t            i_cpu_data_in,
  input  logic                        i_mem_ready,
  input  riscv_pkg::block_t           i_mem_data_out,
  output logic                        o_fsm_mem_wren,
  output logic                        o_fsm_mem_rden,
  output riscv_pkg::blk_addr_t        o_mem_addr,
  output riscv_pkg::block_t           o_cache_data_out,
  output riscv_pkg::xlen_t            o_cpu_data_out,
  output logic                        o_cpu_stall
);

  import riscv_pkg::*;

  index_t                index;
  tag_t                  tag;
  logic [BYTE_OFF-1:0]   byte_off;
  block_t                line;
  logic                  hit;
  logic                  req;
  logic                  store_hit;
  logic                  refill_done;
  logic [DATAPBLOCK-1:0] size_mask;
  logic [DATAPBLOCK-1:0] byte_en;
  block_t                wdata_shift;
  block_t                merged;

  tag_t                   tag_mem  [CACHE_DEPTH];
  block_t                 data_mem [CACHE_DEPTH];
  logic [CACHE_DEPTH-1:0] valid;
  logic [CACHE_DEPTH-1:0] dirty;

  dcache_state_t state;
  dcache_state_t state_nxt;

  assign index    = i_phys_addr[BYTE_OFF +: INDEX];
  assign tag      = i_phys_addr[ADDR-1 -: TAG];
  assign byte_off = i_phys_addr[BYTE_OFF-1:0];
  assign line     = data_mem[index];
  assign hit      = valid[index] && (tag_mem[index] == tag);
  assign req      = i_cpu_wren || i_cpu_rden;

  assign store_hit   = (state == DC_IDLE) && i_cpu_wren && hit;
  assign refill_done = (state == DC_REFILL) && i_mem_ready;

  assign o_cpu_stall      = req && (!hit || (state != DC_IDLE));
  assign o_cpu_data_out   = i_phys_addr[3] ? line[127:64] : line[63:0];
  assign o_fsm_mem_wren   = (state == DC_WRITEBACK);
  assign o_fsm_mem_rden   = (state == DC_REFILL);
  assign o_cache_data_out = line;                // Victim block during writeback.
  assign o_mem_addr       = (state == DC_WRITEBACK) ? {tag_mem[index], index} : {tag, index};

  always_comb begin
    case (i_store_src)
      ST_BYTE:  size_mask = 16'h0001;
      ST_HALF:  size_mask = 16'h0003;
      ST_WORD:  size_mask = 16'h000F;
      default:  size_mask = 16'h00FF;
    endcase
    byte_en     = size_mask << byte_off;           // Stores are naturally aligned.
    wdata_shift = block_t'(i_cpu_data_in) << {byte_off, 3'b000};
    for (int b = 0; b < DATAPBLOCK; b++) begin
      merged[8*b +: 8] = byte_en[b] ? wdata_shift[8*b +: 8] : line[8*b +: 8];
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      DC_IDLE: begin
        if (req && !hit) begin
          if (valid[index] && dirty[index]) begin
            state_nxt = DC_WRITEBACK;
          end else begin
            state_nxt = DC_REFILL;
          end
        end
      end
      DC_WRITEBACK: begin
        if (i_mem_ready) begin
          state_nxt = DC_REFILL;
        end
      end
      DC_REFILL: begin
        if (i_mem_ready) begin
          state_nxt = DC_IDLE;                     // The access retries as a hit.
        end
      end
      default: state_nxt = DC_IDLE;
    endcase
  end

  always_ff @(posedge i_dcache_clk) begin
    if (!i_rst_n) begin
      state <= DC_IDLE;
      valid <= '0;
      dirty <= '0;
    end else begin
      state <= state_nxt;
      if (refill_done) begin
        valid[index] <= 1'b1;
        dirty[index] <= 1'b0;
      end else if (store_hit) begin
        dirty[index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_dcache_clk) begin
    if (refill_done) begin
      data_mem[index] <= i_mem_data_out;
      tag_mem[index]  <= tag;
    end else if (store_hit) begin
      data_mem[index] <= merged;
    end
  end

  a_mem_rd_wr_excl: assert property (@(posedge i_dcache_clk) disable iff (!i_rst_n)
    !(o_fsm_mem_rden && o_fsm_mem_wren));

  // Load and store come from one CPU port, so the decoder never forwards both.
  a_cpu_rd_wr_excl: assert property (@(posedge i_dcache_clk) disable iff (!i_rst_n)
    !(i_cpu_rden && i_cpu_wren));

endmodule

//--- hw/riscv_instructions_cache.sv
module riscv_instructions_cache (
  input  logic                 i_icache_clk,
  input  logic                 i_rst_n,
  input  riscv_pkg::xlen_t     i_pc,
  input  logic                 i_mem_ready,
  input  riscv_pkg::block_t    i_mem_data_out,
  output riscv_pkg::blk_addr_t o_mem_addr,
  output logic                 o_fsm_mem_rden,
  output riscv_pkg::inst_t     o_cpu_instr_out,
  output logic                 o_cpu_stall
);

  import riscv_pkg::*;

  xlen_t           pc_off;
  logic [ADDR-1:0] phys_addr;
  index_t          index;
  tag_t            tag;
  logic [1:0]      word_sel;
  block_t          line;
  logic            hit;

  tag_t                   tag_mem  [CACHE_DEPTH];
  block_t                 data_mem [CACHE_DEPTH];
  logic [CACHE_DEPTH-1:0] valid;

  icache_state_t state;
  icache_state_t state_nxt;

  assign pc_off    = i_pc - KERNEL_PC;            // Fetch space starts at the kernel base.
  assign phys_addr = pc_off[ADDR-1:0];
  assign index     = phys_addr[BYTE_OFF +: INDEX];
  assign tag       = phys_addr[ADDR-1 -: TAG];
  assign word_sel  = phys_addr[3:2];
  assign line      = data_mem[index];
  assign hit       = valid[index] && (tag_mem[index] == tag);

  assign o_cpu_instr_out = line[{word_sel, 5'd0} +: 32];
  assign o_cpu_stall     = !hit || (state != IC_IDLE);
  assign o_fsm_mem_rden  = (state == IC_REFILL);
  assign o_mem_addr      = phys_addr[ADDR-1:BYTE_OFF]; // PC is held while stalled.

  always_comb begin
    state_nxt = state;
    case (state)
      IC_IDLE: begin
        if (!hit) begin
          state_nxt = IC_REFILL;
        end
      end
      IC_REFILL: begin
        if (i_mem_ready) begin
          state_nxt = IC_IDLE;
        end
      end
      default: state_nxt = IC_IDLE;
    endcase
  end

  always_ff @(posedge i_icache_clk) begin
    if (!i_rst_n) begin
      state <= IC_IDLE;
      valid <= '0;
    end else begin
      state <= state_nxt;
      if (o_fsm_mem_rden && i_mem_ready) begin
        valid[index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_icache_clk) begin
    if (o_fsm_mem_rden && i_mem_ready) begin
      data_mem[index] <= i_mem_data_out;
      tag_mem[index]  <= tag;
    end
  end

  a_no_stall_when_idle: assert property (@(posedge i_icache_clk) disable iff (!i_rst_n)
    !o_cpu_stall |-> state == IC_IDLE);

endmodule

//--- hw/riscv_pkg.sv
package riscv_pkg;

  localparam int MXLEN       = 64;
  localparam int DATA_WIDTH  = 128;
  localparam int DATAPBLOCK  = 16;
  localparam int CACHE_DEPTH = 16;
  localparam int MEM_SIZE    = 65536;
  localparam int ADDR        = $clog2(MEM_SIZE);           // 16 bits.
  localparam int BYTE_OFF    = $clog2(DATAPBLOCK);         // 4 bits.
  localparam int INDEX       = $clog2(CACHE_DEPTH);        // 4 bits.
  localparam int TAG         = ADDR - BYTE_OFF - INDEX;    // 8 bits.
  localparam int S_ADDR      = ADDR - BYTE_OFF;            // 12 bits.

  typedef logic [MXLEN-1:0]      xlen_t;
  typedef logic [DATA_WIDTH-1:0] block_t;
  typedef logic [S_ADDR-1:0]     blk_addr_t;
  typedef logic [TAG-1:0]        tag_t;
  typedef logic [INDEX-1:0]      index_t;
  typedef logic [31:0]           inst_t;
  typedef logic [1:0]            store_src_t;
  typedef logic                  timer_sel_t;

  localparam xlen_t KERNEL_PC  = 64'h0000_0000_8000_0000;
  localparam xlen_t TIMER_BASE = 64'h0000_0000_0000_F000;
  localparam xlen_t UART_ADDR  = 64'h0000_0000_0000_F100;

  localparam store_src_t ST_BYTE  = 2'd0;
  localparam store_src_t ST_HALF  = 2'd1;
  localparam store_src_t ST_WORD  = 2'd2;
  localparam store_src_t ST_DWORD = 2'd3;

  localparam timer_sel_t SEL_MTIME    = 1'b0;
  localparam timer_sel_t SEL_MTIMECMP = 1'b1;

  typedef enum logic {
    IC_IDLE,
    IC_REFILL
  } icache_state_t;

  typedef enum logic [1:0] {
    DC_IDLE,
    DC_WRITEBACK,
    DC_REFILL
  } dcache_state_t;

endpackage
